// ==== include/main_defines.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory map constants for the single supported board layout
// Region codes match word address bits 22:20, I/O sub-regions bits 6:4
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MAIN_DEFINES_SVH
`define MAIN_DEFINES_SVH

// Region codes, anything else is unmapped
`define REG_ROM 3'd0
`define REG_RAM 3'd1
`define REG_IO  3'd2

// Cabinet I/O sub-regions
`define IO_PORT   3'd0 // Parallel port bank
`define IO_SW     3'd1 // Switches and DIPs
`define IO_ADC    3'd3 // Analog latch and channel read
`define IO_TOGGLE 3'd7 // Object buffer toggle

// Open bus read value
`define UNMAPPED_DATA 16'hffff

// Upper end of motor travel
`define MOTOR_MAX 16'hff00

`endif

// ==== hw/main_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the main board glue
// Word addressed bus, byte lane 0 is bits 7:0
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package main_pkg;

    typedef logic [23:1] addr_t; // Word address
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] pos_t;  // Motor position, center at 8000

    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_wait,
        st_ack
    } bus_state_t;

    typedef struct packed {
        addr_t      addr;
        logic       we;
        logic [1:0] be;    // Bit 0 is the low byte
        word_t      wdata;
    } bus_req_t;

    // Raw cabinet inputs, switches are active low
    typedef struct packed {
        byte_t      joystick;
        logic       start;
        logic [1:0] coin;
        logic       service;
        logic       test;
        byte_t      dipsw_a;
        byte_t      dipsw_b;
        word_t      steer;
        word_t      pedal;
    } cab_in_t;

    typedef struct packed {
        logic       video_en;
        logic [2:0] adc_ch;
        logic       snd_rstb;
        logic [1:0] obj_cfg;
    } io_cfg_t;

    typedef struct packed {
        pos_t       pos;
        logic [2:0] lim; // {at max, at center, at zero}
    } motor_st_t;

endpackage

// ==== hw/bus_cycle_fsm.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One access at a time, req is dropped unless the FSM is idle
// ROM and RAM hold the cycle until mem_ok, I/O and unmapped take one cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "main_defines.svh"

module bus_cycle_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  main_pkg::bus_req_t bus_req,
    input  logic               mem_ok,
    input  main_pkg::word_t    mem_rdata,
    input  main_pkg::word_t    io_rdata,
    input  logic               rom_cs,
    input  logic               ram_cs,
    input  logic               io_cs,
    output main_pkg::bus_req_t cur_req,
    output logic               cycle_active,
    output logic               cycle_done,
    output logic               ack,
    output main_pkg::word_t    rdata
);
    import main_pkg::*;

    bus_state_t state;
    logic       mem_sel;

    assign mem_sel      = rom_cs || ram_cs;
    assign cycle_done   = (state == st_wait) && (mem_sel ? mem_ok : 1'b1);
    // Chip selects clear on the same edge that ends the wait
    assign cycle_active = (state == st_decode) || ((state == st_wait) && !cycle_done);
    assign ack          = state == st_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (req) state <= st_decode;
                st_decode: state <= st_wait;
                st_wait:   if (cycle_done) state <= st_ack;
                st_ack:    state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            cur_req <= bus_req;
        end
        if (cycle_done) begin
            if (mem_sel) begin
                rdata <= mem_rdata;
            end else if (io_cs) begin
                rdata <= io_rdata;
            end else begin
                rdata <= `UNMAPPED_DATA; // Open bus
            end
        end
    end

endmodule

// ==== hw/region_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Selects are registered, valid one cycle after the request is latched
// ROM writes raise no select and finish as unmapped accesses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "main_defines.svh"

module region_decode (
    input  logic               clk,
    input  logic               rst,
    input  main_pkg::bus_req_t cur_req,
    input  logic               cycle_active,
    output logic               rom_cs,
    output logic               ram_cs,
    output logic               io_cs
);

    logic [2:0] region;

    assign region = cur_req.addr[22:20];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs <= 1'b0;
            ram_cs <= 1'b0;
            io_cs  <= 1'b0;
        end else if (cycle_active) begin
            rom_cs <= (region == `REG_ROM) && !cur_req.we; // Read only
            ram_cs <= region == `REG_RAM;
            io_cs  <= region == `REG_IO;
        end else begin
            rom_cs <= 1'b0;
            ram_cs <= 1'b0;
            io_cs  <= 1'b0;
        end
    end

endmodule

// ==== hw/cab_io.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cabinet I/O, only the low byte is decoded and the upper byte reads ff
// Writes need be[0] and land when the bus cycle completes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "main_defines.svh"

module cab_io (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::bus_req_t  cur_req,
    input  logic                io_cs,
    input  logic                io_done,
    input  main_pkg::cab_in_t   cab,
    input  main_pkg::motor_st_t motor_st,
    output main_pkg::word_t     io_rdata,
    output main_pkg::io_cfg_t   io_cfg,
    output main_pkg::byte_t     port_b,
    output logic                obj_toggle
);
    import main_pkg::*;

    logic [2:0] sub;
    logic [1:0] sel;
    logic       wr;
    byte_t      port_c;
    byte_t      cab_dout;
    byte_t      adc_dout;
    word_t      dac_steer;
    word_t      dac_pedal;

    assign sub = cur_req.addr[6:4];
    assign sel = cur_req.addr[2:1];
    assign wr  = io_cs && io_done && cur_req.we && cur_req.be[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_b     <= '0;
            port_c     <= 8'h21; // Video on, sound out of reset
            dac_steer  <= '0;
            dac_pedal  <= '0;
            obj_toggle <= 1'b0;
        end else begin
            obj_toggle <= io_cs && io_done && (sub == `IO_TOGGLE);
            if (wr) begin
                case (sub)
                    `IO_PORT: begin
                        if (sel == 2'd1) port_b <= cur_req.wdata[7:0];
                        if (sel == 2'd2) port_c <= cur_req.wdata[7:0];
                    end
                    `IO_ADC: begin
                        dac_steer <= cab.steer; // Sample both analog inputs
                        dac_pedal <= cab.pedal;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        io_cfg.obj_cfg  = port_c[7:6];
        io_cfg.video_en = port_c[5];
        io_cfg.adc_ch   = port_c[4:2];
        io_cfg.snd_rstb = port_c[0];
    end

    always_comb begin
        case (io_cfg.adc_ch)
            3'd0: adc_dout = !cab.joystick[0] ? 8'hd0 :
                             !cab.joystick[1] ? 8'h20 :
                             dac_steer[7:0] ^ 8'h80; // Wheel
            3'd1: adc_dout = !cab.joystick[3] ? 8'hf0 :
                             dac_pedal[15] ? ~{dac_pedal[14:8], dac_pedal[14]} : 8'h00;
            3'd2: adc_dout = !cab.joystick[2] ? 8'hf0 :
                             dac_pedal[15] ? 8'h00 : {dac_pedal[14:8], dac_pedal[14]};
            3'd3: adc_dout = motor_st.pos[15:8];
            default: adc_dout = 8'hff;
        endcase
    end

    always_comb begin
        cab_dout = 8'hff;
        case (sub)
            `IO_PORT: case (sel)
                2'd0: cab_dout = {5'b11111, motor_st.lim};
                2'd1: cab_dout = port_b;
                2'd2: cab_dout = port_c;
                default: ;
            endcase
            `IO_SW: case (sel)
                2'd0: cab_dout = {cab.coin, ~cab.joystick[4], cab.joystick[4],
                                  cab.start, cab.service, cab.test, 1'b1};
                2'd2: cab_dout = cab.dipsw_a;
                2'd3: cab_dout = cab.dipsw_b;
                default: ;
            endcase
            `IO_ADC: cab_dout = adc_dout;
            default: ;
        endcase
    end

    assign io_rdata = {8'hff, cab_dout};

endmodule

// ==== hw/motor_pos.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Moves once per vint by (ctrl[7:4]+1)*256, direction from ctrl[1:0]
// Position saturates at 0 and MOTOR_MAX
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "main_defines.svh"

module motor_pos (
    input  logic                clk,
    input  logic                rst,
    input  logic                vint,
    input  main_pkg::byte_t     ctrl,
    output main_pkg::motor_st_t motor_st
);
    import main_pkg::*;

    localparam pos_t CENTER = 16'h8000;

    pos_t        pos;
    pos_t        step;
    logic [16:0] up_sum;

    assign step   = {3'd0, {1'b0, ctrl[7:4]} + 5'd1, 8'h00};
    assign up_sum = {1'b0, pos} + {1'b0, step};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= CENTER;
        end else if (vint) begin
            case (ctrl[1:0])
                2'b01: pos <= (up_sum > {1'b0, `MOTOR_MAX}) ? `MOTOR_MAX : up_sum[15:0];
                2'b10: pos <= (pos < step) ? '0 : pos - step;
                default: ; // Motor idle
            endcase
        end
    end

    assign motor_st.pos = pos;
    assign motor_st.lim = {pos == `MOTOR_MAX, pos == CENTER, pos == '0};

endmodule

// ==== hw/main_bus.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main board glue top, single bus master with req/ack strobes
// Memory outputs follow the latched request for the whole access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_bus (
    input  logic               clk,
    input  logic               rst,
    // Bus master
    input  logic               req,
    input  main_pkg::bus_req_t bus_req,
    output logic               ack,
    output main_pkg::word_t    rdata,
    // ROM and work RAM
    output logic               rom_cs,
    output logic               ram_cs,
    output main_pkg::addr_t    mem_addr,
    output logic               mem_we,
    output logic [1:0]         mem_be,
    output main_pkg::word_t    mem_wdata,
    input  main_pkg::word_t    mem_rdata,
    input  logic               mem_ok,
    // Board side
    input  main_pkg::cab_in_t  cab,
    input  logic               vint,
    output main_pkg::io_cfg_t  io_cfg,
    output main_pkg::byte_t    motor_ctrl,
    output logic               obj_toggle
);
    import main_pkg::*;

    bus_req_t  cur_req;
    logic      cycle_active;
    logic      cycle_done;
    logic      io_cs;
    word_t     io_rdata;
    motor_st_t motor_st;

    assign mem_addr  = cur_req.addr;
    assign mem_we    = cur_req.we;
    assign mem_be    = cur_req.be;
    assign mem_wdata = cur_req.wdata;

    bus_cycle_fsm i_bus_cycle_fsm (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .bus_req      (bus_req),
        .mem_ok       (mem_ok),
        .mem_rdata    (mem_rdata),
        .io_rdata     (io_rdata),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .io_cs        (io_cs),
        .cur_req      (cur_req),
        .cycle_active (cycle_active),
        .cycle_done   (cycle_done),
        .ack          (ack),
        .rdata        (rdata)
    );

    region_decode i_region_decode (
        .clk          (clk),
        .rst          (rst),
        .cur_req      (cur_req),
        .cycle_active (cycle_active),
        .rom_cs       (rom_cs),
        .ram_cs       (ram_cs),
        .io_cs        (io_cs)
    );

    cab_io i_cab_io (
        .clk        (clk),
        .rst        (rst),
        .cur_req    (cur_req),
        .io_cs      (io_cs),
        .io_done    (cycle_done),
        .cab        (cab),
        .motor_st   (motor_st),
        .io_rdata   (io_rdata),
        .io_cfg     (io_cfg),
        .port_b     (motor_ctrl), // Port B drives the motor
        .obj_toggle (obj_toggle)
    );

    motor_pos i_motor_pos (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .ctrl     (motor_ctrl),
        .motor_st (motor_st)
    );

endmodule

// ==== testbench/main_bus_sva.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus protocol properties, bound into every main_bus instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_bus_sva (
    input logic clk,
    input logic rst,
    input logic ack,
    input logic rom_cs,
    input logic ram_cs,
    input logic io_cs
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held high for more than one cycle");

    one_select: assert property (@(posedge clk) disable iff (rst)
                                 $onehot0({rom_cs, ram_cs, io_cs}))
        else $error("more than one chip select high");

    ack_low_in_reset: assert property (@(posedge clk) rst |-> !ack)
        else $error("ack high while reset is asserted");

endmodule

bind main_bus main_bus_sva i_main_bus_sva (
    .clk    (clk),
    .rst    (rst),
    .ack    (ack),
    .rom_cs (rom_cs),
    .ram_cs (ram_cs),
    .io_cs  (io_cs)
);

// ==== testbench/main_bus_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random bus traffic from a fixed xorshift seed against a reference model
// RAM model holds 16 words, aliased over the whole RAM region
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "main_defines.svh"

module main_bus_tb;
    import main_pkg::*;

    logic       clk;
    logic       rst;
    logic       req;
    logic       ack;
    logic       rom_cs;
    logic       ram_cs;
    logic       mem_we;
    logic       mem_ok = 1'b0;
    logic       vint;
    logic       obj_toggle;
    logic [1:0] mem_be;
    bus_req_t   bus_req;
    addr_t      mem_addr;
    word_t      rdata;
    word_t      mem_wdata;
    word_t      mem_rdata = '0;
    cab_in_t    cab;
    io_cfg_t    io_cfg;
    io_cfg_t    exp_cfg;
    byte_t      motor_ctrl;

    logic [31:0] rng;
    word_t       ram [16];     // Memory model
    word_t       ref_ram [16]; // Expected RAM contents
    byte_t       m_port_b;
    byte_t       m_port_c;
    word_t       m_steer;
    word_t       m_pedal;
    pos_t        m_pos;
    int          mem_delay = 0;
    int          mem_cnt = 0;
    int          cycles = 0;
    int          toggles = 0;
    int          exp_toggles;
    int          errors;
    int          checks;

    main_bus i_main_bus (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Worst access is about 10 cycles, 400 of them
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 5000) begin
            $display("Timeout after %0d cycles, bus traffic did not complete", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (obj_toggle === 1'b1) toggles++;
    end

    // ROM and RAM raise mem_ok mem_delay falling edges after the select
    always @(negedge clk) begin
        if (!(rom_cs || ram_cs)) begin
            mem_ok = 1'b0;
            mem_cnt = mem_delay;
        end else if (!mem_ok && mem_cnt > 0) begin
            mem_cnt--;
        end else if (!mem_ok) begin
            mem_ok = 1'b1;
            mem_rdata = rom_cs ? rom_word(mem_addr) : ram[mem_addr[4:1]];
            if (ram_cs && mem_we && mem_be[0]) ram[mem_addr[4:1]][7:0] = mem_wdata[7:0];
            if (ram_cs && mem_we && mem_be[1]) ram[mem_addr[4:1]][15:8] = mem_wdata[15:8];
        end
    end

    function automatic logic [31:0] xorshift_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t rom_word(input addr_t a);
        return a[16:1] ^ 16'ha5a5;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Low byte that the cabinet I/O block should return
    function automatic byte_t io_expect(input addr_t a);
        logic [7:0] pv;
        pv = {m_pedal[14:8], m_pedal[14]};
        if (a[6:4] == `IO_PORT) begin
            if (a[2:1] == 2'd0)
                return {5'b11111, m_pos == `MOTOR_MAX, m_pos == 16'h8000, m_pos == 16'h0};
            if (a[2:1] == 2'd1) return m_port_b;
            if (a[2:1] == 2'd2) return m_port_c;
        end else if (a[6:4] == `IO_SW) begin
            if (a[2:1] == 2'd0)
                return {cab.coin, ~cab.joystick[4], cab.joystick[4], cab.start,
                        cab.service, cab.test, 1'b1};
            if (a[2:1] == 2'd2) return cab.dipsw_a;
            if (a[2:1] == 2'd3) return cab.dipsw_b;
        end else if (a[6:4] == `IO_ADC) begin
            case (m_port_c[4:2])
                3'd0: return !cab.joystick[0] ? 8'hd0 :
                             !cab.joystick[1] ? 8'h20 : {~m_steer[7], m_steer[6:0]};
                3'd1: return !cab.joystick[3] ? 8'hf0 : m_pedal[15] ? ~pv : 8'h00;
                3'd2: return !cab.joystick[2] ? 8'hf0 : m_pedal[15] ? 8'h00 : pv;
                3'd3: return m_pos[15:8];
                default: return 8'hff;
            endcase
        end
        return 8'hff;
    endfunction

    task automatic move_motor();
        int step;
        int p;
        step = (int'(m_port_b[7:4]) + 1) * 256;
        p = int'(m_pos);
        if (m_port_b[1:0] == 2'b01) p = (p + step > 'hff00) ? 'hff00 : p + step;
        if (m_port_b[1:0] == 2'b10) p = (p < step) ? 0 : p - step;
        m_pos = 16'(p);
    endtask

    task automatic check_cfg();
        exp_cfg.obj_cfg  = m_port_c[7:6];
        exp_cfg.video_en = m_port_c[5];
        exp_cfg.adc_ch   = m_port_c[4:2];
        exp_cfg.snd_rstb = m_port_c[0];
        check("io_cfg", {9'h0, io_cfg}, {9'h0, exp_cfg});
        check("motor_ctrl", {8'h0, motor_ctrl}, {8'h0, m_port_b});
    endtask

    // Compare one finished access at its ack, then update the model
    task automatic check_access(input bus_req_t r, input int lat);
        logic [2:0] region;
        logic       tog;
        region = r.addr[22:20];
        tog = (region == `REG_IO) && (r.addr[6:4] == `IO_TOGGLE);
        if (region == `REG_ROM && !r.we) begin
            check("rdata", rdata, rom_word(r.addr));
        end else if (region == `REG_RAM) begin
            if (!r.we) check("rdata", rdata, ref_ram[r.addr[4:1]]);
            if (r.we && r.be[0]) ref_ram[r.addr[4:1]][7:0] = r.wdata[7:0];
            if (r.we && r.be[1]) ref_ram[r.addr[4:1]][15:8] = r.wdata[15:8];
        end else begin
            check("ack latency", 16'(lat), 16'd3); // I/O, unmapped and ROM writes
            if (!r.we)
                check("rdata", rdata,
                      region == `REG_IO ? {8'hff, io_expect(r.addr)} : `UNMAPPED_DATA);
        end
        check("obj_toggle", {15'h0, obj_toggle}, {15'h0, tog});
        check("rom_cs and ram_cs", {14'h0, rom_cs, ram_cs}, 16'h0);
        if (tog) exp_toggles++;
        if (region == `REG_IO && r.we && r.be[0]) begin
            if (r.addr[6:4] == `IO_PORT && r.addr[2:1] == 2'd1) m_port_b = r.wdata[7:0];
            if (r.addr[6:4] == `IO_PORT && r.addr[2:1] == 2'd2) m_port_c = r.wdata[7:0];
            if (r.addr[6:4] == `IO_ADC) begin
                m_steer = cab.steer; // Sampled at the write
                m_pedal = cab.pedal;
            end
        end
        check_cfg();
    endtask

    initial begin
        bus_req_t    r;
        logic [63:0] wide;
        logic [31:0] pick;
        logic [31:0] rnd;
        logic [2:0]  region;
        int          lat;
        rst = 1'b1;
        req = 1'b0;
        vint = 1'b0;
        bus_req = '0;
        cab = '0;
        rng = 32'h9227;
        errors = 0;
        checks = 0;
        exp_toggles = 0;
        m_port_b = 8'h00;
        m_port_c = 8'h21;
        m_steer = '0;
        m_pedal = '0;
        m_pos = 16'h8000;
        for (int i = 0; i < 16; i++) begin
            ram[i] = {i[3:0], ~i[3:0], i[3:0], ~i[3:0]};
            ref_ram[i] = ram[i];
        end
        repeat (10) @(negedge clk);
        check("ack, selects and obj_toggle in reset",
              {12'h0, ack, rom_cs, ram_cs, obj_toggle}, 16'h0);
        check_cfg();
        rst = 1'b0;

        repeat (400) begin
            pick = xorshift_next();
            rnd = xorshift_next();
            if (pick[1:0] == 2'b00) begin // Frame interrupt between accesses
                vint = 1'b1;
                @(negedge clk);
                vint = 1'b0;
                move_motor();
            end
            wide[63:32] = xorshift_next();
            wide[31:0] = xorshift_next();
            cab = wide[60:0];
            region = (pick[4:2] < 3'd3) ? pick[4:2] : (pick[5] ? `REG_IO : pick[4:2]);
            r.addr = rnd[22:0];
            r.addr[22:20] = region;
            case (pick[7:6])
                2'd0: r.addr[6:4] = `IO_PORT;
                2'd1: r.addr[6:4] = `IO_SW;
                2'd2: r.addr[6:4] = `IO_ADC;
                default: r.addr[6:4] = pick[8] ? `IO_TOGGLE : rnd[6:4];
            endcase
            r.we = pick[10];
            r.be = {pick[11], pick[12] | pick[13]};
            r.wdata = pick[31:16];
            mem_delay = int'(rnd[31:29]) % 6;
            bus_req = r;
            req = 1'b1;
            @(negedge clk);
            req = 1'b0;
            lat = 1;
            while (!ack && lat < 20) begin
                @(negedge clk);
                lat++;
            end
            assert (ack) else begin
                errors++;
                $display("No ack within 20 cycles for address %h", r.addr);
            end
            check_access(r, lat);
            @(negedge clk); // FSM back in idle
        end

        check("obj_toggle pulse count", 16'(toggles), 16'(exp_toggles));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hw/main_pkg.sv
hw/bus_cycle_fsm.sv
hw/region_decode.sv
hw/cab_io.sv
hw/motor_pos.sv
hw/main_bus.sv
testbench/main_bus_sva.sv
testbench/main_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run with Verilator, the log decides pass or fail
rm -f sim.log && \
verilator --binary --timing --assert -f vlog.f --top-module main_bus_tb -o main_bus_sim && \
./obj_dir/main_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
